// ==== hw/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  // pixel position, also used for the raw counters
  typedef logic [11:0] coord_t;

  // 4 bits per channel, red in the top nibble
  typedef logic [11:0] rgb_t;

  // 1024x768 XGA, syncs active low
  localparam int H_ACTIVE = 1024;
  localparam int H_FRONT  = 24;
  localparam int H_SYNC   = 136;
  localparam int H_TOTAL  = 1344;

  localparam int V_ACTIVE = 768;
  localparam int V_FRONT  = 3;
  localparam int V_SYNC   = 6;
  localparam int V_TOTAL  = 806;

endpackage

`default_nettype wire

// ==== hw/game_pkg.sv ====
`default_nettype none

package game_pkg;

  typedef enum logic [1:0] {
    MENU,
    PLAY,
    OVER
  } game_state_t;

  typedef logic [1:0] hp_t;

  // hit points at game start
  localparam hp_t HP_MAX = 2'd3;

  // outer edges of the play area
  localparam int TOP_V_LINE    = 317;
  localparam int BOTTOM_V_LINE = 617;
  localparam int LEFT_H_LINE   = 361;
  localparam int RIGHT_H_LINE  = 661;

  localparam int BORDER      = 7;
  localparam int PILLAR_W    = 16;
  localparam int CURSOR_SIZE = 4;

  localparam vga_pkg::rgb_t OUTSIDE_COLOR = 12'h124;
  localparam vga_pkg::rgb_t BORDER_COLOR  = 12'hbbb;
  localparam vga_pkg::rgb_t FIELD_COLOR   = 12'h031;
  // field tint once the hit points run out
  localparam vga_pkg::rgb_t OVER_COLOR    = 12'h700;
  localparam vga_pkg::rgb_t PILLAR_COLOR  = 12'hf80;
  localparam vga_pkg::rgb_t CURSOR_COLOR  = 12'hfff;

endpackage

`default_nettype wire

// ==== hw/vga_timing.sv ====
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
  parameter int H_FRONT  = vga_pkg::H_FRONT,
  parameter int H_SYNC   = vga_pkg::H_SYNC,
  parameter int H_TOTAL  = vga_pkg::H_TOTAL,
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
  parameter int V_FRONT  = vga_pkg::V_FRONT,
  parameter int V_SYNC   = vga_pkg::V_SYNC,
  parameter int V_TOTAL  = vga_pkg::V_TOTAL
) (
  input  wire             pclk,
  input  wire             rst,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output logic            hsync,
  output logic            vsync,
  output logic            blank
);

  vga_pkg::coord_t hcount_nxt;
  vga_pkg::coord_t vcount_nxt;

  always_comb begin
    hcount_nxt = hcount + 1'b1;
    vcount_nxt = vcount;
    if (hcount == H_TOTAL - 1) begin
      hcount_nxt = '0;
      if (vcount == V_TOTAL - 1) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount + 1'b1;
      end
    end
  end

  // sync and blank follow the next count so all outputs line up
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      blank  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= !(hcount_nxt >= H_ACTIVE + H_FRONT &&
                  hcount_nxt < H_ACTIVE + H_FRONT + H_SYNC);
      vsync  <= !(vcount_nxt >= V_ACTIVE + V_FRONT &&
                  vcount_nxt < V_ACTIVE + V_FRONT + V_SYNC);
      blank  <= (hcount_nxt >= H_ACTIVE) || (vcount_nxt >= V_ACTIVE);
    end
  end

  assert property (@(posedge pclk) disable iff (rst)
    hcount < H_TOTAL && vcount < V_TOTAL);

endmodule

`default_nettype wire

// ==== hw/game_control.sv ====
`default_nettype none

module game_control (
  input  wire                   pclk,
  input  wire                   rst,
  input  wire                   game_button,
  input  wire                   menu_button,
  input  wire                   hit,
  output game_pkg::game_state_t state,
  output logic                  game_over
);

  game_pkg::hp_t hp;

  always_ff @(posedge pclk) begin
    if (rst) begin
      state <= game_pkg::MENU;
      hp    <= '0;
    end else if (menu_button) begin
      // menu wins over everything else
      state <= game_pkg::MENU;
    end else begin
      case (state)
        game_pkg::MENU: begin
          if (game_button) begin
            state <= game_pkg::PLAY;
            hp    <= game_pkg::HP_MAX;
          end
        end
        game_pkg::PLAY: begin
          if (hit) begin
            hp <= hp - 1'b1;
            if (hp == 2'd1) begin
              state <= game_pkg::OVER;
            end
          end
        end
        game_pkg::OVER: begin
          state <= game_pkg::OVER;
        end
        default: begin
          state <= game_pkg::MENU;
        end
      endcase
    end
  end

  assign game_over = (state == game_pkg::OVER);

  // a live game always has at least one hit point left
  assert property (@(posedge pclk) disable iff (rst)
    state == game_pkg::PLAY |-> hp != '0 && hp <= game_pkg::HP_MAX);

endmodule

`default_nettype wire

// ==== hw/pillar_obstacle.sv ====
`default_nettype none

module pillar_obstacle #(
  parameter int V_ACTIVE      = vga_pkg::V_ACTIVE,
  parameter int TOP_V_LINE    = game_pkg::TOP_V_LINE,
  parameter int BOTTOM_V_LINE = game_pkg::BOTTOM_V_LINE,
  parameter int LEFT_H_LINE   = game_pkg::LEFT_H_LINE,
  parameter int RIGHT_H_LINE  = game_pkg::RIGHT_H_LINE,
  parameter int BORDER        = game_pkg::BORDER,
  parameter int PILLAR_W      = game_pkg::PILLAR_W
) (
  input  wire                   pclk,
  input  wire                   rst,
  input  wire vga_pkg::coord_t  hcount,
  input  wire vga_pkg::coord_t  vcount,
  input  wire vga_pkg::coord_t  xpos,
  input  wire vga_pkg::coord_t  ypos,
  input  wire game_pkg::game_state_t state,
  output vga_pkg::coord_t       pillar_x,
  output logic                  hit
);

  // travel range of the pillar's left edge
  localparam vga_pkg::coord_t X_MIN = vga_pkg::coord_t'(LEFT_H_LINE + BORDER);
  localparam vga_pkg::coord_t X_MAX = vga_pkg::coord_t'(RIGHT_H_LINE - BORDER - PILLAR_W);
  localparam int Y_MIN = TOP_V_LINE + BORDER;
  localparam int Y_MAX = BOTTOM_V_LINE - BORDER;

  logic frame_event;
  logic cursor_in_pillar;
  logic moving_right;

  // start of vertical blanking
  assign frame_event = (hcount == '0) && (vcount == V_ACTIVE);

  assign cursor_in_pillar = (xpos >= pillar_x) && (xpos < pillar_x + PILLAR_W) &&
                            (ypos >= Y_MIN) && (ypos < Y_MAX);

  always_ff @(posedge pclk) begin
    if (rst || state != game_pkg::PLAY) begin
      pillar_x     <= X_MIN;
      moving_right <= 1'b1;
      hit          <= 1'b0;
    end else begin
      hit <= frame_event && cursor_in_pillar;
      if (frame_event) begin
        if (moving_right && pillar_x == X_MAX) begin
          moving_right <= 1'b0;
          pillar_x     <= pillar_x - 1'b1;
        end else if (!moving_right && pillar_x == X_MIN) begin
          moving_right <= 1'b1;
          pillar_x     <= pillar_x + 1'b1;
        end else if (moving_right) begin
          pillar_x <= pillar_x + 1'b1;
        end else begin
          pillar_x <= pillar_x - 1'b1;
        end
      end
    end
  end

  assert property (@(posedge pclk) disable iff (rst)
    pillar_x >= X_MIN && pillar_x <= X_MAX);

endmodule

`default_nettype wire

// ==== hw/draw_background.sv ====
`default_nettype none

module draw_background #(
  parameter int TOP_V_LINE    = game_pkg::TOP_V_LINE,
  parameter int BOTTOM_V_LINE = game_pkg::BOTTOM_V_LINE,
  parameter int LEFT_H_LINE   = game_pkg::LEFT_H_LINE,
  parameter int RIGHT_H_LINE  = game_pkg::RIGHT_H_LINE,
  parameter int BORDER        = game_pkg::BORDER
) (
  input  wire                        pclk,
  input  wire                        rst,
  input  wire vga_pkg::coord_t       hcount_in,
  input  wire vga_pkg::coord_t       vcount_in,
  input  wire                        hsync_in,
  input  wire                        vsync_in,
  input  wire                        blank_in,
  input  wire game_pkg::game_state_t state,
  output vga_pkg::coord_t            hcount_out,
  output vga_pkg::coord_t            vcount_out,
  output logic                       hsync_out,
  output logic                       vsync_out,
  output logic                       blank_out,
  output vga_pkg::rgb_t              rgb_out
);

  logic          in_outer;
  logic          in_inner;
  vga_pkg::rgb_t rgb_nxt;

  assign in_outer = (hcount_in >= LEFT_H_LINE) && (hcount_in < RIGHT_H_LINE) &&
                    (vcount_in >= TOP_V_LINE) && (vcount_in < BOTTOM_V_LINE);
  assign in_inner = (hcount_in >= LEFT_H_LINE + BORDER) &&
                    (hcount_in < RIGHT_H_LINE - BORDER) &&
                    (vcount_in >= TOP_V_LINE + BORDER) &&
                    (vcount_in < BOTTOM_V_LINE - BORDER);

  always_comb begin
    if (in_inner) begin
      rgb_nxt = (state == game_pkg::OVER) ? game_pkg::OVER_COLOR : game_pkg::FIELD_COLOR;
    end else if (in_outer) begin
      rgb_nxt = game_pkg::BORDER_COLOR;
    end else begin
      rgb_nxt = game_pkg::OUTSIDE_COLOR;
    end
  end

  always_ff @(posedge pclk) begin
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
    rgb_out    <= rgb_nxt;
    if (rst) begin
      hsync_out <= 1'b1;
      vsync_out <= 1'b1;
      blank_out <= 1'b1;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
    end
  end

endmodule

`default_nettype wire

// ==== hw/draw_obstacle.sv ====
`default_nettype none

module draw_obstacle #(
  parameter int TOP_V_LINE    = game_pkg::TOP_V_LINE,
  parameter int BOTTOM_V_LINE = game_pkg::BOTTOM_V_LINE,
  parameter int BORDER        = game_pkg::BORDER,
  parameter int PILLAR_W      = game_pkg::PILLAR_W
) (
  input  wire                        pclk,
  input  wire                        rst,
  input  wire vga_pkg::coord_t       hcount_in,
  input  wire vga_pkg::coord_t       vcount_in,
  input  wire                        hsync_in,
  input  wire                        vsync_in,
  input  wire                        blank_in,
  input  wire vga_pkg::rgb_t         rgb_in,
  input  wire game_pkg::game_state_t state,
  input  wire vga_pkg::coord_t       pillar_x,
  output vga_pkg::coord_t            hcount_out,
  output vga_pkg::coord_t            vcount_out,
  output logic                       hsync_out,
  output logic                       vsync_out,
  output logic                       blank_out,
  output vga_pkg::rgb_t              rgb_out
);

  logic in_pillar;

  // pillar spans the whole inner field height
  assign in_pillar = (state == game_pkg::PLAY) &&
                     (hcount_in >= pillar_x) && (hcount_in < pillar_x + PILLAR_W) &&
                     (vcount_in >= TOP_V_LINE + BORDER) &&
                     (vcount_in < BOTTOM_V_LINE - BORDER);

  always_ff @(posedge pclk) begin
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
    rgb_out    <= in_pillar ? game_pkg::PILLAR_COLOR : rgb_in;
    if (rst) begin
      hsync_out <= 1'b1;
      vsync_out <= 1'b1;
      blank_out <= 1'b1;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
    end
  end

endmodule

`default_nettype wire

// ==== hw/draw_cursor.sv ====
`default_nettype none

module draw_cursor (
  input  wire                  pclk,
  input  wire                  rst,
  input  wire vga_pkg::coord_t hcount_in,
  input  wire vga_pkg::coord_t vcount_in,
  input  wire                  hsync_in,
  input  wire                  vsync_in,
  input  wire                  blank_in,
  input  wire vga_pkg::rgb_t   rgb_in,
  input  wire vga_pkg::coord_t xpos,
  input  wire vga_pkg::coord_t ypos,
  output logic                 hs,
  output logic                 vs,
  output logic [3:0]           r,
  output logic [3:0]           g,
  output logic [3:0]           b
);

  logic          in_cursor;
  vga_pkg::rgb_t rgb_nxt;

  // square with its top left corner at the cursor point
  assign in_cursor = (hcount_in >= xpos) && (hcount_in < xpos + game_pkg::CURSOR_SIZE) &&
                     (vcount_in >= ypos) && (vcount_in < ypos + game_pkg::CURSOR_SIZE);

  always_comb begin
    if (blank_in) begin
      rgb_nxt = '0;
    end else if (in_cursor) begin
      rgb_nxt = game_pkg::CURSOR_COLOR;
    end else begin
      rgb_nxt = rgb_in;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hs        <= 1'b1;
      vs        <= 1'b1;
      {r, g, b} <= '0;
    end else begin
      hs        <= hsync_in;
      vs        <= vsync_in;
      {r, g, b} <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== hw/game_top.sv ====
`default_nettype none

module game_top #(
  parameter int H_ACTIVE      = vga_pkg::H_ACTIVE,
  parameter int H_FRONT       = vga_pkg::H_FRONT,
  parameter int H_SYNC        = vga_pkg::H_SYNC,
  parameter int H_TOTAL       = vga_pkg::H_TOTAL,
  parameter int V_ACTIVE      = vga_pkg::V_ACTIVE,
  parameter int V_FRONT       = vga_pkg::V_FRONT,
  parameter int V_SYNC        = vga_pkg::V_SYNC,
  parameter int V_TOTAL       = vga_pkg::V_TOTAL,
  parameter int TOP_V_LINE    = game_pkg::TOP_V_LINE,
  parameter int BOTTOM_V_LINE = game_pkg::BOTTOM_V_LINE,
  parameter int LEFT_H_LINE   = game_pkg::LEFT_H_LINE,
  parameter int RIGHT_H_LINE  = game_pkg::RIGHT_H_LINE,
  parameter int BORDER        = game_pkg::BORDER,
  parameter int PILLAR_W      = game_pkg::PILLAR_W
) (
  input  wire                  pclk,
  input  wire                  rst,
  input  wire                  game_button,
  input  wire                  menu_button,
  input  wire vga_pkg::coord_t xpos,
  input  wire vga_pkg::coord_t ypos,
  output logic                 hs,
  output logic                 vs,
  output logic [3:0]           r,
  output logic [3:0]           g,
  output logic [3:0]           b,
  output logic                 game_over
);

  vga_pkg::coord_t       hcount_tim, vcount_tim, hcount_bg, vcount_bg, hcount_obs, vcount_obs;
  logic                  hsync_tim, vsync_tim, blank_tim;
  logic                  hsync_bg, vsync_bg, blank_bg;
  logic                  hsync_obs, vsync_obs, blank_obs;
  vga_pkg::rgb_t         rgb_bg, rgb_obs;
  vga_pkg::coord_t       pillar_x;
  logic                  hit;
  game_pkg::game_state_t state;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
  ) u_vga_timing (
    .pclk(pclk), .rst(rst),
    .hcount(hcount_tim), .vcount(vcount_tim),
    .hsync(hsync_tim), .vsync(vsync_tim), .blank(blank_tim)
  );

  // game side
  game_control u_game_control (
    .pclk(pclk), .rst(rst),
    .game_button(game_button), .menu_button(menu_button), .hit(hit),
    .state(state), .game_over(game_over)
  );

  pillar_obstacle #(
    .V_ACTIVE(V_ACTIVE),
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE),
    .BORDER(BORDER), .PILLAR_W(PILLAR_W)
  ) u_pillar_obstacle (
    .pclk(pclk), .rst(rst),
    .hcount(hcount_tim), .vcount(vcount_tim),
    .xpos(xpos), .ypos(ypos), .state(state),
    .pillar_x(pillar_x), .hit(hit)
  );

  // drawing pipeline, one cycle per stage
  draw_background #(
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE), .BORDER(BORDER)
  ) u_draw_background (
    .pclk(pclk), .rst(rst),
    .hcount_in(hcount_tim), .vcount_in(vcount_tim),
    .hsync_in(hsync_tim), .vsync_in(vsync_tim), .blank_in(blank_tim), .state(state),
    .hcount_out(hcount_bg), .vcount_out(vcount_bg),
    .hsync_out(hsync_bg), .vsync_out(vsync_bg), .blank_out(blank_bg), .rgb_out(rgb_bg)
  );

  draw_obstacle #(
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .BORDER(BORDER), .PILLAR_W(PILLAR_W)
  ) u_draw_obstacle (
    .pclk(pclk), .rst(rst),
    .hcount_in(hcount_bg), .vcount_in(vcount_bg),
    .hsync_in(hsync_bg), .vsync_in(vsync_bg), .blank_in(blank_bg), .rgb_in(rgb_bg),
    .state(state), .pillar_x(pillar_x),
    .hcount_out(hcount_obs), .vcount_out(vcount_obs),
    .hsync_out(hsync_obs), .vsync_out(vsync_obs), .blank_out(blank_obs), .rgb_out(rgb_obs)
  );

  draw_cursor u_draw_cursor (
    .pclk(pclk), .rst(rst),
    .hcount_in(hcount_obs), .vcount_in(vcount_obs),
    .hsync_in(hsync_obs), .vsync_in(vsync_obs), .blank_in(blank_obs), .rgb_in(rgb_obs),
    .xpos(xpos), .ypos(ypos),
    .hs(hs), .vs(vs), .r(r), .g(g), .b(b)
  );

endmodule

`default_nettype wire

// ==== test/game_model.svh ====
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

// expected behavior from the game rules, using the testbench screen constants

function automatic bit in_range(int val, int lo, int hi);
  return (val >= lo) && (val < hi);
endfunction

function automatic vga_pkg::rgb_t expected_pixel(int h, int v, game_pkg::game_state_t st,
                                                 int px, int cx, int cy);
  if (!in_range(h, 0, H_ACTIVE) || !in_range(v, 0, V_ACTIVE)) begin
    return '0;
  end
  if (in_range(h, cx, cx + game_pkg::CURSOR_SIZE) &&
      in_range(v, cy, cy + game_pkg::CURSOR_SIZE)) begin
    return game_pkg::CURSOR_COLOR;
  end
  // pillar only exists in the inner field rows
  if (st == game_pkg::PLAY && in_range(h, px, px + PILLAR_W) &&
      in_range(v, TOP_V_LINE + BORDER, BOTTOM_V_LINE - BORDER)) begin
    return game_pkg::PILLAR_COLOR;
  end
  if (in_range(h, LEFT_H_LINE + BORDER, RIGHT_H_LINE - BORDER) &&
      in_range(v, TOP_V_LINE + BORDER, BOTTOM_V_LINE - BORDER)) begin
    return (st == game_pkg::OVER) ? game_pkg::OVER_COLOR : game_pkg::FIELD_COLOR;
  end
  if (in_range(h, LEFT_H_LINE, RIGHT_H_LINE) && in_range(v, TOP_V_LINE, BOTTOM_V_LINE)) begin
    return game_pkg::BORDER_COLOR;
  end
  return game_pkg::OUTSIDE_COLOR;
endfunction

// cursor point against the pillar as it stood before the frame step
function automatic bit cursor_hits_pillar(int px, int cx, int cy);
  return in_range(cx, px, px + PILLAR_W) &&
         in_range(cy, TOP_V_LINE + BORDER, BOTTOM_V_LINE - BORDER);
endfunction

function automatic int next_pillar_x(int px, bit right);
  if (right) begin
    return (px + 1 > X_MAX) ? px - 1 : px + 1;
  end
  return (px - 1 < X_MIN) ? px + 1 : px - 1;
endfunction

function automatic bit next_direction(int px, bit right);
  if (right && px + 1 > X_MAX) begin
    return 1'b0;
  end
  if (!right && px - 1 < X_MIN) begin
    return 1'b1;
  end
  return right;
endfunction

function automatic game_pkg::hp_t next_hp(game_pkg::hp_t hp, bit hit);
  return hit ? hp - 1'b1 : hp;
endfunction

function automatic game_pkg::game_state_t next_state(game_pkg::game_state_t st,
                                                     game_pkg::hp_t hp, bit hit);
  if (st == game_pkg::PLAY && hit && hp == 1) begin
    return game_pkg::OVER;
  end
  return st;
endfunction

`endif

// ==== test/tb_game_top.sv ====
`default_nettype none

module tb_game_top;

  localparam int CLK_PERIOD    = 20;
  localparam int H_ACTIVE      = 64;
  localparam int H_FRONT       = 4;
  localparam int H_SYNC        = 8;
  localparam int H_TOTAL       = 80;
  localparam int V_ACTIVE      = 48;
  localparam int V_FRONT       = 2;
  localparam int V_SYNC        = 3;
  localparam int V_TOTAL       = 56;
  localparam int TOP_V_LINE    = 8;
  localparam int BOTTOM_V_LINE = 40;
  localparam int LEFT_H_LINE   = 8;
  localparam int RIGHT_H_LINE  = 56;
  localparam int BORDER        = 2;
  localparam int PILLAR_W      = 4;
  localparam int X_MIN         = LEFT_H_LINE + BORDER;
  localparam int X_MAX         = RIGHT_H_LINE - BORDER - PILLAR_W;
  localparam int HP_START      = game_pkg::HP_MAX;
  localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
  localparam int MENU_FRAMES   = 3;
  // long enough for the pillar to reach the right end and turn
  localparam int PLAY_FRAMES   = 44;
  localparam int TEST_FRAMES   = 2 + (MENU_FRAMES + 1) + (PLAY_FRAMES + 1) +
                                 (HP_START + 1) + (HP_START + 1);

  logic            pclk;
  logic            rst;
  logic            game_button;
  logic            menu_button;
  vga_pkg::coord_t xpos;
  vga_pkg::coord_t ypos;
  logic            hs;
  logic            vs;
  logic [3:0]      r;
  logic [3:0]      g;
  logic [3:0]      b;
  logic            game_over;

  int    tcount;
  int    err_count = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    test_errs_start = 0;
  string cur_test;

  // reference game state
  game_pkg::game_state_t m_state;
  game_pkg::hp_t         m_hp;
  int                    m_px;
  bit                    m_right;

  `include "game_model.svh"

  game_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL),
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE),
    .BORDER(BORDER), .PILLAR_W(PILLAR_W)
  ) dut (
    .pclk(pclk), .rst(rst), .game_button(game_button), .menu_button(menu_button),
    .xpos(xpos), .ypos(ypos),
    .hs(hs), .vs(vs), .r(r), .g(g), .b(b), .game_over(game_over)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_count++;
    $display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what, exp, act);
  endtask

  // sees exactly what the DUT samples on each rising edge
  always @(posedge pclk) begin : compare
    int                    o;
    int                    oh;
    int                    ov;
    int                    th;
    int                    tv;
    int                    new_px;
    bit                    hit_now;
    bit                    exp_hs;
    bit                    exp_vs;
    vga_pkg::rgb_t         exp_rgb;
    game_pkg::game_state_t new_state;
    if (rst) begin
      tcount  = 0;
      m_state = game_pkg::MENU;
      m_hp    = '0;
      m_px    = X_MIN;
      m_right = 1'b1;
    end else begin
      // outputs trail the timing counters by three stages
      o = tcount - 3;
      oh = -1;
      ov = -1;
      exp_hs = 1'b1;
      exp_vs = 1'b1;
      exp_rgb = '0;
      if (o >= 0) begin
        oh = o % H_TOTAL;
        ov = (o / H_TOTAL) % V_TOTAL;
        exp_hs = !in_range(oh, H_ACTIVE + H_FRONT, H_ACTIVE + H_FRONT + H_SYNC);
        exp_vs = !in_range(ov, V_ACTIVE + V_FRONT, V_ACTIVE + V_FRONT + V_SYNC);
        exp_rgb = expected_pixel(oh, ov, m_state, m_px, xpos, ypos);
      end
      if (hs !== exp_hs) begin
        report_mismatch($sformatf("hs at %0d,%0d", oh, ov), exp_hs, hs);
      end
      if (vs !== exp_vs) begin
        report_mismatch($sformatf("vs at %0d,%0d", oh, ov), exp_vs, vs);
      end
      if ({r, g, b} !== exp_rgb) begin
        report_mismatch($sformatf("rgb at %0d,%0d", oh, ov), exp_rgb, {r, g, b});
      end
      th = tcount % H_TOTAL;
      tv = (tcount / H_TOTAL) % V_TOTAL;
      if (menu_button) begin
        m_state = game_pkg::MENU;
      end else if (m_state == game_pkg::MENU && game_button) begin
        m_state = game_pkg::PLAY;
        m_hp    = game_pkg::HP_MAX;
      end else if (m_state == game_pkg::PLAY && th == 0 && tv == V_ACTIVE) begin
        hit_now   = cursor_hits_pillar(m_px, xpos, ypos);
        new_state = next_state(m_state, m_hp, hit_now);
        m_hp      = next_hp(m_hp, hit_now);
        new_px    = next_pillar_x(m_px, m_right);
        m_right   = next_direction(m_px, m_right);
        m_px      = new_px;
        m_state   = new_state;
      end
      if (m_state != game_pkg::PLAY) begin
        m_px    = X_MIN;
        m_right = 1'b1;
      end
      tcount++;
    end
  end

  task automatic wait_vblank();
    @(negedge pclk);
    while (!((tcount % H_TOTAL) == 10 && ((tcount / H_TOTAL) % V_TOTAL) == V_ACTIVE + 1)) begin
      @(negedge pclk);
    end
  endtask

  task automatic pulse_button(input bit menu);
    if (menu) begin
      menu_button = 1'b1;
    end else begin
      game_button = 1'b1;
    end
    @(negedge pclk);
    menu_button = 1'b0;
    game_button = 1'b0;
  endtask

  task automatic place_clear();
    // rows above the play area never touch the field
    xpos = $urandom % (H_ACTIVE - game_pkg::CURSOR_SIZE + 1);
    ypos = $urandom % (TOP_V_LINE - game_pkg::CURSOR_SIZE + 1);
  endtask

  task automatic place_on_pillar();
    xpos = m_px + 1;
    ypos = TOP_V_LINE + BORDER + 10;
  endtask

  task automatic check_game_over(input bit exp);
    if (game_over !== exp) begin
      report_mismatch("game_over", exp, game_over);
    end
  endtask

  task automatic count_sync_lows(output int hs_lows, output int vs_lows);
    hs_lows = 0;
    vs_lows = 0;
    repeat (FRAME_CYCLES) begin
      @(negedge pclk);
      if (!hs) begin
        hs_lows++;
      end
      if (!vs) begin
        vs_lows++;
      end
    end
  endtask

  task automatic hit_until_over();
    int k;
    for (k = 1; k <= HP_START; k++) begin
      place_on_pillar();
      wait_vblank();
      if (k < HP_START) begin
        check_game_over(1'b0);
      end
    end
    check_game_over(1'b1);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_errs_start) begin
      pass_count++;
      $display("test %s: passed", cur_test);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", cur_test, err_count - test_errs_start);
    end
  endtask

  initial begin : stimulus
    int seed_val;
    int hs_lows;
    int vs_lows;
    seed_val = $urandom(32'h3692);
    rst = 1'b1;
    game_button = 1'b0;
    menu_button = 1'b0;
    xpos = '0;
    ypos = '0;
    cur_test = "sync_and_blank";
    repeat (4) @(negedge pclk);
    rst = 1'b0;

    begin_test("sync_and_blank");
    wait_vblank();
    count_sync_lows(hs_lows, vs_lows);
    if (hs_lows != V_TOTAL * H_SYNC) begin
      report_mismatch("hs low cycles per frame", V_TOTAL * H_SYNC, hs_lows);
    end
    if (vs_lows != V_SYNC * H_TOTAL) begin
      report_mismatch("vs low cycles per frame", V_SYNC * H_TOTAL, vs_lows);
    end
    end_test();

    begin_test("menu_frame");
    repeat (MENU_FRAMES) begin
      wait_vblank();
      check_game_over(1'b0);
      xpos = $urandom % H_ACTIVE;
      ypos = $urandom % V_ACTIVE;
    end
    wait_vblank();
    end_test();

    begin_test("play_motion");
    wait_vblank();
    place_clear();
    pulse_button(1'b0);
    repeat (PLAY_FRAMES) begin
      wait_vblank();
      check_game_over(1'b0);
      place_clear();
    end
    end_test();

    begin_test("hits_to_game_over");
    hit_until_over();
    // this frame shows the OVER field
    wait_vblank();
    check_game_over(1'b1);
    end_test();

    begin_test("return_to_menu");
    pulse_button(1'b1);
    wait_vblank();
    check_game_over(1'b0);
    pulse_button(1'b0);
    hit_until_over();
    end_test();

    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_FRAMES + 4) * FRAME_CYCLES * CLK_PERIOD);
    $display("watchdog expired, test sequence did not complete in %0d frames", TEST_FRAMES + 4);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== game_top.f ====
+incdir+test
hw/vga_pkg.sv
hw/game_pkg.sv
hw/vga_timing.sv
hw/game_control.sv
hw/pillar_obstacle.sv
hw/draw_background.sv
hw/draw_obstacle.sv
hw/draw_cursor.sv
hw/game_top.sv
test/tb_game_top.sv
